//--- source/st_link_pkg.sv
package st_link_pkg;

  ////////////////////
  // Link word

  // Word is {tlast, tkeep, tdata}
  localparam int data_width = 64;
  localparam int keep_width = 8;
  localparam int word_width = 73;

  ////////////////////
  // PHY frame

  localparam int phy_width      = 80;
  localparam int phy_push_bit   = 73;
  localparam int phy_credit_bit = 74;
  // Bits above the strobe stay zero
  localparam int phy_strobe_bit = 75;

  ////////////////////
  // Receive FIFO and credits

  localparam int rx_depth       = 8;
  localparam int rx_ptr_width   = 3;
  localparam int rx_count_width = 4;
  localparam int credit_width   = 8;

  ////////////////////
  // Online sequencer

  typedef enum logic [1:0] {
    sync_off,
    sync_wait,
    sync_on
  } sync_state_t;

endpackage

//--- source/link_online_sync.sv
`timescale 1ns/10ps

module link_online_sync import st_link_pkg::*; (
  input  logic        clk_wr,
  input  logic        rst,
  input  logic        tx_online,
  input  logic        rx_online,
  input  logic [15:0] delay_x_value,
  input  logic [15:0] delay_y_value,
  output logic        tx_online_delay,
  output logic        rx_online_delay,
  output logic        strobe
);

  sync_state_t tx_state;
  sync_state_t tx_state_next;
  sync_state_t rx_state;
  sync_state_t rx_state_next;
  logic [15:0] tx_cnt;
  logic [15:0] rx_cnt;
  logic        tx_hold;

  // Tx side stays on into the next cycle
  assign tx_hold = tx_online_delay & tx_online;

  ////////////////////
  // Tx sequencer

  always_comb begin
    tx_state_next = tx_state;
    case (tx_state)
      sync_off: begin
        if (tx_online) tx_state_next = sync_wait;
      end
      sync_wait: begin
        if (!tx_online) tx_state_next = sync_off;
        else if (tx_cnt == delay_x_value) tx_state_next = sync_on;
      end
      sync_on: begin
        if (!tx_online) tx_state_next = sync_off;
      end
      default: tx_state_next = sync_off;
    endcase
  end

  ////////////////////
  // Rx sequencer

  // Only starts counting once tx is fully online
  always_comb begin
    rx_state_next = rx_state;
    case (rx_state)
      sync_off: begin
        if (rx_online && tx_hold) rx_state_next = sync_wait;
      end
      sync_wait: begin
        if (!rx_online || !tx_hold) rx_state_next = sync_off;
        else if (rx_cnt == delay_y_value) rx_state_next = sync_on;
      end
      sync_on: begin
        if (!rx_online || !tx_hold) rx_state_next = sync_off;
      end
      default: rx_state_next = sync_off;
    endcase
  end

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      tx_state <= sync_off;
      rx_state <= sync_off;
      tx_cnt   <= '0;
      rx_cnt   <= '0;
      strobe   <= 1'b0;
    end else begin
      tx_state <= tx_state_next;
      rx_state <= rx_state_next;
      // Counters run only while waiting
      tx_cnt   <= (tx_state == sync_wait) ? tx_cnt + 16'd1 : '0;
      rx_cnt   <= (rx_state == sync_wait) ? rx_cnt + 16'd1 : '0;
      // One shot on the rising edge of tx_online_delay
      strobe   <= (tx_state_next == sync_on) && (tx_state != sync_on);
    end
  end

  assign tx_online_delay = (tx_state == sync_on);
  assign rx_online_delay = (rx_state == sync_on);

endmodule

//--- source/link_transmit.sv
`timescale 1ns/10ps

module link_transmit import st_link_pkg::*; (
  input  logic                    clk_wr,
  input  logic                    rst,
  input  logic                    tx_online_delay,
  input  logic                    rx_online_delay,
  input  logic [credit_width-1:0] init_m2s_credit,

  // User m2s stream
  input  logic [keep_width-1:0]   user_m2s_tkeep,
  input  logic [data_width-1:0]   user_m2s_tdata,
  input  logic                    user_m2s_tlast,
  input  logic                    user_m2s_tvalid,
  output logic                    user_m2s_tready,

  // Towards the PHY framer
  input  logic                    credit_in,
  output logic [word_width-1:0]   tx_word,
  output logic                    tx_push,

  output logic [31:0]             tx_debug_status
);

  logic                    link_up;
  logic                    credit_loaded;
  logic [credit_width-1:0] credit_cnt;

  assign link_up = tx_online_delay & rx_online_delay;

  ////////////////////
  // Handshake and packing

  // Ready never looks at valid
  assign user_m2s_tready = link_up && (credit_cnt != '0);
  assign tx_push         = user_m2s_tvalid & user_m2s_tready;
  assign tx_word         = {user_m2s_tlast, user_m2s_tkeep, user_m2s_tdata};

  ////////////////////
  // Credit counter

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      credit_cnt    <= '0;
      credit_loaded <= 1'b0;
    end else if (!link_up) begin
      // Far side credits are meaningless while down
      credit_cnt    <= '0;
      credit_loaded <= 1'b0;
    end else if (!credit_loaded) begin
      credit_cnt    <= init_m2s_credit;
      credit_loaded <= 1'b1;
    end else begin
      case ({tx_push, credit_in})
        2'b10:   credit_cnt <= credit_cnt - 1'b1;
        2'b01:   credit_cnt <= credit_cnt + 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

  // Credits in the low byte, link state above
  assign tx_debug_status = {{(32 - credit_width - 1){1'b0}}, link_up, credit_cnt};

endmodule

//--- source/link_receive.sv
`timescale 1ns/10ps

module link_receive import st_link_pkg::*; (
  input  logic                  clk_wr,
  input  logic                  rst,
  input  logic                  tx_online_delay,
  input  logic                  rx_online_delay,

  // From the PHY framer
  input  logic [word_width-1:0] rx_word,
  input  logic                  rx_push,

  // User s2m stream
  output logic [keep_width-1:0] user_s2m_tkeep,
  output logic [data_width-1:0] user_s2m_tdata,
  output logic                  user_s2m_tlast,
  output logic                  user_s2m_tvalid,
  input  logic                  user_s2m_tready,

  output logic                  credit_out,
  output logic [31:0]           rx_debug_status
);

  logic                      link_up;
  logic [word_width-1:0]     fifo_mem [rx_depth];
  logic [word_width-1:0]     head_word;
  logic [rx_ptr_width-1:0]   wr_ptr;
  logic [rx_ptr_width-1:0]   rd_ptr;
  logic [rx_count_width-1:0] rx_count;
  logic                      fifo_full;
  logic                      push;
  logic                      pop;
  logic                      overflow;

  assign link_up   = tx_online_delay & rx_online_delay;
  assign fifo_full = (rx_count == rx_count_width'(rx_depth));

  // Frames arriving while down are ignored
  assign push = rx_push & link_up & ~fifo_full;
  assign pop  = user_s2m_tvalid & user_s2m_tready;

  ////////////////////
  // FIFO storage

  always_ff @(posedge clk_wr) begin
    if (push) fifo_mem[wr_ptr] <= rx_word;
  end

  ////////////////////
  // Pointers and count

  always_ff @(posedge clk_wr) begin
    if (rst || !link_up) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      rx_count <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   rx_count <= rx_count + 1'b1;
        2'b01:   rx_count <= rx_count - 1'b1;
        default: rx_count <= rx_count;
      endcase
    end
  end

  // Sticky until reset
  always_ff @(posedge clk_wr) begin
    if (rst) overflow <= 1'b0;
    else if (rx_push && link_up && fifo_full) overflow <= 1'b1;
  end

  ////////////////////
  // Show-ahead output

  assign head_word       = fifo_mem[rd_ptr];
  assign user_s2m_tdata  = head_word[data_width-1:0];
  assign user_s2m_tkeep  = head_word[data_width +: keep_width];
  assign user_s2m_tlast  = head_word[word_width-1];
  assign user_s2m_tvalid = (rx_count != '0);

  // One credit back per word taken
  assign credit_out = pop;

  assign rx_debug_status = {23'b0, overflow, {(8 - rx_count_width){1'b0}}, rx_count};

endmodule

//--- source/link_phy_frame.sv
`timescale 1ns/10ps

module link_phy_frame import st_link_pkg::*; (
  input  logic                  clk_wr,
  input  logic                  rst,

  // Outgoing fields
  input  logic [word_width-1:0] tx_word,
  input  logic                  tx_push,
  input  logic                  credit_ret,
  input  logic                  strobe,

  // PHY lane
  output logic [phy_width-1:0]  tx_phy0,
  input  logic [phy_width-1:0]  rx_phy0,

  // Incoming fields
  output logic [word_width-1:0] rx_word,
  output logic                  rx_push,
  output logic                  credit_in
);

  logic [phy_width-1:0] frame_next;

  ////////////////////
  // Transmit frame

  always_comb begin
    frame_next = '0;
    // Idle frames carry no stale data
    frame_next[word_width-1:0]  = tx_push ? tx_word : '0;
    frame_next[phy_push_bit]    = tx_push;
    frame_next[phy_credit_bit]  = credit_ret;
    frame_next[phy_strobe_bit]  = strobe;
  end

  always_ff @(posedge clk_wr) begin
    if (rst) tx_phy0 <= '0;
    else tx_phy0 <= frame_next;
  end

  ////////////////////
  // Receive frame

  // Straight slices, no register on this side
  assign rx_word   = rx_phy0[word_width-1:0];
  assign rx_push   = rx_phy0[phy_push_bit];
  assign credit_in = rx_phy0[phy_credit_bit];

endmodule

//--- source/st_link_top.sv
`timescale 1ns/10ps

module st_link_top import st_link_pkg::*; (
  input  logic                    clk_wr,
  input  logic                    rst,

  // Link control
  input  logic                    tx_online,
  input  logic                    rx_online,
  input  logic [credit_width-1:0] init_m2s_credit,
  input  logic [15:0]             delay_x_value,
  input  logic [15:0]             delay_y_value,

  // PHY lane
  output logic [phy_width-1:0]    tx_phy0,
  input  logic [phy_width-1:0]    rx_phy0,

  // m2s stream
  input  logic [keep_width-1:0]   user_m2s_tkeep,
  input  logic [data_width-1:0]   user_m2s_tdata,
  input  logic                    user_m2s_tlast,
  input  logic                    user_m2s_tvalid,
  output logic                    user_m2s_tready,

  // s2m stream
  output logic [keep_width-1:0]   user_s2m_tkeep,
  output logic [data_width-1:0]   user_s2m_tdata,
  output logic                    user_s2m_tlast,
  output logic                    user_s2m_tvalid,
  input  logic                    user_s2m_tready,

  output logic [31:0]             tx_debug_status,
  output logic [31:0]             rx_debug_status
);

  ////////////////////
  // Interconnect

  logic                  tx_online_delay;
  logic                  rx_online_delay;
  logic                  strobe;
  logic [word_width-1:0] tx_word;
  logic                  tx_push;
  logic [word_width-1:0] rx_word;
  logic                  rx_push;
  logic                  credit_in;
  logic                  credit_out;

  link_online_sync sync_i (
    .clk_wr          (clk_wr),
    .rst             (rst),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_x_value   (delay_x_value),
    .delay_y_value   (delay_y_value),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .strobe          (strobe)
  );

  link_transmit tx_i (
    .clk_wr          (clk_wr),
    .rst             (rst),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .init_m2s_credit (init_m2s_credit),
    .user_m2s_tkeep  (user_m2s_tkeep),
    .user_m2s_tdata  (user_m2s_tdata),
    .user_m2s_tlast  (user_m2s_tlast),
    .user_m2s_tvalid (user_m2s_tvalid),
    .user_m2s_tready (user_m2s_tready),
    .credit_in       (credit_in),
    .tx_word         (tx_word),
    .tx_push         (tx_push),
    .tx_debug_status (tx_debug_status)
  );

  link_receive rx_i (
    .clk_wr          (clk_wr),
    .rst             (rst),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .rx_word         (rx_word),
    .rx_push         (rx_push),
    .user_s2m_tkeep  (user_s2m_tkeep),
    .user_s2m_tdata  (user_s2m_tdata),
    .user_s2m_tlast  (user_s2m_tlast),
    .user_s2m_tvalid (user_s2m_tvalid),
    .user_s2m_tready (user_s2m_tready),
    .credit_out      (credit_out),
    .rx_debug_status (rx_debug_status)
  );

  // Credit return rides on the outgoing frame
  link_phy_frame frame_i (
    .clk_wr     (clk_wr),
    .rst        (rst),
    .tx_word    (tx_word),
    .tx_push    (tx_push),
    .credit_ret (credit_out),
    .strobe     (strobe),
    .tx_phy0    (tx_phy0),
    .rx_phy0    (rx_phy0),
    .rx_word    (rx_word),
    .rx_push    (rx_push),
    .credit_in  (credit_in)
  );

endmodule

//--- tests/st_link_props.sv
`timescale 1ns/10ps

module st_link_props import st_link_pkg::*; (
  input logic                      clk_wr,
  input logic                      rst,
  input logic                      ready,
  input logic [credit_width-1:0]   credit_cnt,
  input logic                      credit_pulse,
  input logic                      pop,
  input logic [rx_count_width-1:0] count
);

  int fail_count = 0;

  // No word may leave without a credit
  assert property (@(posedge clk_wr) disable iff (rst) ready |-> (credit_cnt != '0))
    else begin
      fail_count++;
      $error("tready high with zero credits");
    end

  assert property (@(posedge clk_wr) disable iff (rst) credit_pulse |-> pop)
    else begin
      fail_count++;
      $error("credit returned without a pop");
    end

  assert property (@(posedge clk_wr) disable iff (rst)
                   count <= rx_count_width'(rx_depth))
    else begin
      fail_count++;
      $error("receive FIFO count above depth");
    end

endmodule

// Unused checks are tied off per block
bind link_transmit st_link_props tx_props (
  .clk_wr       (clk_wr),
  .rst          (rst),
  .ready        (user_m2s_tready),
  .credit_cnt   (credit_cnt),
  .credit_pulse (1'b0),
  .pop          (1'b0),
  .count        (4'd0)
);

bind link_receive st_link_props rx_props (
  .clk_wr       (clk_wr),
  .rst          (rst),
  .ready        (1'b0),
  .credit_cnt   (8'd1),
  .credit_pulse (credit_out),
  .pop          (pop),
  .count        (rx_count)
);

//--- tests/st_link_tb.sv
`timescale 1ns/10ps

module st_link_tb import st_link_pkg::*; ();

  logic                    clk_wr = 1'b0;
  logic                    rst;
  logic                    tx_online;
  logic                    rx_online;
  logic [credit_width-1:0] init_m2s_credit;
  logic [15:0]             delay_x_value;
  logic [15:0]             delay_y_value;
  logic [phy_width-1:0]    tx_phy0;
  logic [phy_width-1:0]    rx_phy0;
  logic [keep_width-1:0]   user_m2s_tkeep;
  logic [data_width-1:0]   user_m2s_tdata;
  logic                    user_m2s_tlast;
  logic                    user_m2s_tvalid;
  logic                    user_m2s_tready;
  logic [keep_width-1:0]   user_s2m_tkeep;
  logic [data_width-1:0]   user_s2m_tdata;
  logic                    user_s2m_tlast;
  logic                    user_s2m_tvalid;
  logic                    user_s2m_tready;
  logic [31:0]             tx_debug_status;
  logic [31:0]             rx_debug_status;

  integer                  seed = 32'haeac;
  int                      errors = 0;
  int                      assert_fails;
  bit                      link_up_model = 1'b0;
  logic [word_width-1:0]   rx_expect [$];

  st_link_top dut (.*);

  always #4 clk_wr = ~clk_wr;

  ////////////////////
  // Helpers

  task automatic next_cycle();
    @(posedge clk_wr);
    #1;
  endtask

  task automatic check(input string name, input logic [79:0] got, input logic [79:0] exp);
    if (got !== exp) begin
      errors++;
      $display("FAIL %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic make_word(output logic [word_width-1:0] w);
    w = {1'($random(seed)), 8'($random(seed)), $random(seed), $random(seed)};
  endtask

  // Frame layout as seen on the lane
  function automatic logic [phy_width-1:0] push_frame(input logic [word_width-1:0] w);
    logic [phy_width-1:0] f;
    f = '0;
    f[word_width-1:0] = w;
    f[phy_push_bit] = 1'b1;
    return f;
  endfunction

  task automatic wait_m2s_ready();
    int n;
    n = 0;
    while (!user_m2s_tready && n < 50) begin
      next_cycle();
      n++;
    end
    if (!user_m2s_tready) begin
      errors++;
      $display("Timed out waiting for user_m2s_tready");
    end
  endtask

  task automatic wait_s2m_valid();
    int n;
    n = 0;
    while (!user_s2m_tvalid && n < 50) begin
      next_cycle();
      n++;
    end
    if (!user_s2m_tvalid) begin
      errors++;
      $display("Timed out waiting for user_s2m_tvalid");
    end
  endtask

  task automatic send_word(input logic [word_width-1:0] w);
    user_m2s_tdata  = w[data_width-1:0];
    user_m2s_tkeep  = w[data_width +: keep_width];
    user_m2s_tlast  = w[word_width-1];
    user_m2s_tvalid = 1'b1;
    wait_m2s_ready();
    next_cycle();
    check("tx_phy0", tx_phy0, push_frame(w));
  endtask

  // Far side pushes n words, model drops what a full FIFO cannot hold
  task automatic push_rx_frames(input int n);
    logic [word_width-1:0] w;
    for (int i = 0; i < n; i++) begin
      make_word(w);
      rx_phy0 = push_frame(w);
      if (link_up_model && rx_expect.size() < rx_depth) rx_expect.push_back(w);
      next_cycle();
      // No credits go back while the user holds off
      check("tx_phy0", tx_phy0, 80'h0);
    end
    rx_phy0 = '0;
  endtask

  task automatic drain_s2m(input int n);
    logic [word_width-1:0] exp;
    int credits;
    credits = 0;
    user_s2m_tready = 1'b1;
    for (int i = 0; i < n; i++) begin
      wait_s2m_valid();
      exp = rx_expect.pop_front();
      check("user_s2m_tdata", 80'(user_s2m_tdata), 80'(exp[data_width-1:0]));
      check("user_s2m_tkeep", 80'(user_s2m_tkeep), 80'(exp[data_width +: keep_width]));
      check("user_s2m_tlast", 80'(user_s2m_tlast), 80'(exp[word_width-1]));
      next_cycle();
      if (tx_phy0[phy_credit_bit]) credits++;
      check("tx_phy0", tx_phy0, 80'(1) << phy_credit_bit);
    end
    user_s2m_tready = 1'b0;
    check("credit frames", 80'(credits), 80'(n));
    check("user_s2m_tvalid", 80'(user_s2m_tvalid), 80'h0);
  endtask

  ////////////////////
  // Tests

  task automatic reset_test();
    check("tx_phy0", tx_phy0, 80'h0);
    check("user_m2s_tready", 80'(user_m2s_tready), 80'h0);
    check("user_s2m_tvalid", 80'(user_s2m_tvalid), 80'h0);
    check("tx_debug_status", 80'(tx_debug_status), 80'h0);
    check("rx_debug_status", 80'(rx_debug_status), 80'h0);
  endtask

  task automatic online_test();
    int strobes;
    int strobe_edge;
    int rx_up_edge;
    strobes = 0;
    strobe_edge = -1;
    delay_x_value   = 16'd5;
    delay_y_value   = 16'd3;
    init_m2s_credit = 8'd3;
    tx_online = 1'b1;
    rx_online = 1'b1;
    // Tx up after delay_x+1 edges, rx sees it one edge later, then delay_y+1
    rx_up_edge = (delay_x_value + 1) + 1 + (delay_y_value + 1);
    // First edge to see tx_online high
    next_cycle();
    for (int e = 1; e <= 24; e++) begin
      next_cycle();
      if (tx_phy0[phy_strobe_bit]) begin
        strobes++;
        strobe_edge = e;
        check("tx_phy0", tx_phy0, 80'(1) << phy_strobe_bit);
      end else begin
        check("tx_phy0", tx_phy0, 80'h0);
      end
      check("rx_online_delay", 80'(dut.rx_online_delay), 80'(e >= rx_up_edge));
      if (e < rx_up_edge) check("user_m2s_tready", 80'(user_m2s_tready), 80'h0);
    end
    check("strobe frames", 80'(strobes), 80'd1);
    check("strobe edge", 80'(strobe_edge), 80'd7);
    link_up_model = 1'b1;
    wait_m2s_ready();
    // Link up flag above the loaded credits
    check("tx_debug_status", 80'(tx_debug_status), 80'h103);
  endtask

  task automatic credit_test();
    logic [word_width-1:0] w;
    int accepted;
    accepted = 0;
    for (int i = 0; i < 3; i++) begin
      make_word(w);
      send_word(w);
    end
    make_word(w);
    user_m2s_tdata  = w[data_width-1:0];
    user_m2s_tkeep  = w[data_width +: keep_width];
    user_m2s_tlast  = w[word_width-1];
    repeat (10) begin
      check("user_m2s_tready", 80'(user_m2s_tready), 80'h0);
      next_cycle();
      check("tx_phy0", tx_phy0, 80'h0);
    end
    // One credit back from the far side
    rx_phy0 = 80'(1) << phy_credit_bit;
    next_cycle();
    rx_phy0 = '0;
    repeat (10) begin
      next_cycle();
      if (tx_phy0[phy_push_bit]) begin
        accepted++;
        check("tx_phy0", tx_phy0, push_frame(w));
      end
    end
    check("words after credit", 80'(accepted), 80'd1);
    user_m2s_tvalid = 1'b0;
  endtask

  task automatic receive_test();
    push_rx_frames(4);
    drain_s2m(4);
  endtask

  task automatic overflow_test();
    push_rx_frames(rx_depth + 1);
    check("rx_debug_status", 80'(rx_debug_status), 80'h108);
    drain_s2m(rx_depth);
  endtask

  task automatic link_drop_test();
    tx_online = 1'b0;
    link_up_model = 1'b0;
    next_cycle();
    check("user_m2s_tready", 80'(user_m2s_tready), 80'h0);
    check("tx_online_delay", 80'(dut.tx_online_delay), 80'h0);
    check("rx_online_delay", 80'(dut.rx_online_delay), 80'h0);
    check("tx_debug_status", 80'(tx_debug_status), 80'h0);
    push_rx_frames(2);
    repeat (5) begin
      check("user_s2m_tvalid", 80'(user_s2m_tvalid), 80'h0);
      next_cycle();
    end
    // Overflow flag survives the drop
    check("rx_debug_status", 80'(rx_debug_status), 80'h100);
  endtask

  ////////////////////
  // Main sequence

  initial begin
    rst             = 1'b1;
    tx_online       = 1'b0;
    rx_online       = 1'b0;
    init_m2s_credit = '0;
    delay_x_value   = '0;
    delay_y_value   = '0;
    rx_phy0         = '0;
    user_m2s_tkeep  = '0;
    user_m2s_tdata  = '0;
    user_m2s_tlast  = 1'b0;
    user_m2s_tvalid = 1'b0;
    user_s2m_tready = 1'b0;
    repeat (2) @(posedge clk_wr);
    #1;
    rst = 1'b0;
    reset_test();
    online_test();
    credit_test();
    receive_test();
    overflow_test();
    link_drop_test();
    assert_fails = dut.tx_i.tx_props.fail_count + dut.rx_i.rx_props.fail_count;
    errors += assert_fails;
    $display("Error count: %0d (assertion failures %0d)", errors, assert_fails);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  initial begin
    #200000;
    $display("Run stopped by watchdog, tests did not finish");
    $display("Simulation FAILED");
    $finish;
  end

endmodule

//--- st_link_top.f
source/st_link_pkg.sv
source/link_online_sync.sv
source/link_transmit.sv
source/link_receive.sv
source/link_phy_frame.sv
source/st_link_top.sv
tests/st_link_props.sv
tests/st_link_tb.sv

//--- Makefile
# Verilator flow for the credit link

FILELIST = st_link_top.f
LOG      = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module st_link_tb -f $(FILELIST)

sim:
	verilator --binary --timing --assert --top-module st_link_tb -f $(FILELIST) -o st_link_sim
	-./obj_dir/st_link_sim > $(LOG) 2>&1
	cat $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
